// ==== include/demo_program.svh ====
`ifndef DEMO_PROGRAM_SVH
`define DEMO_PROGRAM_SVH

// alu and immediate group
mem[0]  = {op_ldi,  4'd1,  4'd0, 19'd12};           // ldi r1, 12
mem[1]  = {op_ldi,  4'd2,  4'd0, 19'd5};            // ldi r2, 5
mem[2]  = {op_add,  4'd3,  4'd1, 4'd2, 15'd0};      // add r3, r1, r2
mem[3]  = {op_out,  4'd3,  4'd0, 19'd0};            // out 0x11
mem[4]  = {op_sub,  4'd3,  4'd1, 4'd2, 15'd0};      // sub r3, r1, r2
mem[5]  = {op_out,  4'd3,  4'd0, 19'd0};            // out 0x7
mem[6]  = {op_and,  4'd3,  4'd1, 4'd2, 15'd0};      // and r3, r1, r2
mem[7]  = {op_out,  4'd3,  4'd0, 19'd0};            // out 0x4
mem[8]  = {op_or,   4'd3,  4'd1, 4'd2, 15'd0};      // or r3, r1, r2
mem[9]  = {op_out,  4'd3,  4'd0, 19'd0};            // out 0xd
mem[10] = {op_shl,  4'd3,  4'd1, 4'd2, 15'd0};      // shl r3, r1, r2
mem[11] = {op_out,  4'd3,  4'd0, 19'd0};            // out 0x180
mem[12] = {op_shr,  4'd4,  4'd3, 4'd2, 15'd0};      // shr r4, r3, r2
mem[13] = {op_out,  4'd4,  4'd0, 19'd0};            // out 0xc
mem[14] = {op_addi, 4'd5,  4'd1, 19'h7ffec};        // addi r5, r1, -20
mem[15] = {op_out,  4'd5,  4'd0, 19'd0};            // out 0xfffffff8
mem[16] = {op_andi, 4'd6,  4'd5, 19'h000ff};        // andi r6, r5, 0xff
mem[17] = {op_out,  4'd6,  4'd0, 19'd0};            // out 0xf8
mem[18] = {op_ori,  4'd7,  4'd1, 19'h00300};        // ori r7, r1, 0x300
mem[19] = {op_out,  4'd7,  4'd0, 19'd0};            // out 0x30c
// store then load back through a negative offset
mem[20] = {op_add,  4'd10, 4'd7, 4'd6, 15'd0};      // add r10, r7, r6 = 0x404
mem[21] = {op_st,   4'd10, 4'd1, 19'h00080};        // st 0x80(r1), r10 -> mem[140]
mem[22] = {op_ldi,  4'd8,  4'd0, 19'd150};          // ldi r8, 150
mem[23] = {op_ld,   4'd9,  4'd8, 19'h7fff6};        // ld r9, -10(r8)
mem[24] = {op_out,  4'd9,  4'd0, 19'd0};            // out 0x404
mem[25] = {op_ld,   4'd11, 4'd0, 19'd100};          // ld r11, 100, no base
mem[26] = {op_out,  4'd11, 4'd0, 19'd0};            // out 0x13579bdf
// branches, each skips an ldi/out pair of 0xbad when taken
mem[27] = {op_br,   4'd1,  4'd0, 19'd2};            // brzr r1 not taken
mem[28] = {op_ldi,  4'd12, 4'd0, 19'h101};
mem[29] = {op_out,  4'd12, 4'd0, 19'd0};            // out 0x101
mem[30] = {op_br,   4'd0,  4'd0, 19'd2};            // brzr r0 taken
mem[31] = {op_ldi,  4'd12, 4'd0, 19'hbad};
mem[32] = {op_out,  4'd12, 4'd0, 19'd0};
mem[33] = {op_ldi,  4'd12, 4'd0, 19'h102};
mem[34] = {op_out,  4'd12, 4'd0, 19'd0};            // out 0x102
mem[35] = {op_br,   4'd0,  4'd1, 19'd2};            // brnz r0 not taken
mem[36] = {op_ldi,  4'd12, 4'd0, 19'h103};
mem[37] = {op_out,  4'd12, 4'd0, 19'd0};            // out 0x103
mem[38] = {op_br,   4'd1,  4'd1, 19'd2};            // brnz r1 taken
mem[39] = {op_ldi,  4'd12, 4'd0, 19'hbad};
mem[40] = {op_out,  4'd12, 4'd0, 19'd0};
mem[41] = {op_ldi,  4'd12, 4'd0, 19'h104};
mem[42] = {op_out,  4'd12, 4'd0, 19'd0};            // out 0x104
mem[43] = {op_br,   4'd5,  4'd2, 19'd2};            // brpl r5 not taken
mem[44] = {op_ldi,  4'd12, 4'd0, 19'h105};
mem[45] = {op_out,  4'd12, 4'd0, 19'd0};            // out 0x105
mem[46] = {op_br,   4'd1,  4'd2, 19'd2};            // brpl r1 taken
mem[47] = {op_ldi,  4'd12, 4'd0, 19'hbad};
mem[48] = {op_out,  4'd12, 4'd0, 19'd0};
mem[49] = {op_ldi,  4'd12, 4'd0, 19'h106};
mem[50] = {op_out,  4'd12, 4'd0, 19'd0};            // out 0x106
mem[51] = {op_br,   4'd1,  4'd3, 19'd2};            // brmi r1 not taken
mem[52] = {op_ldi,  4'd12, 4'd0, 19'h107};
mem[53] = {op_out,  4'd12, 4'd0, 19'd0};            // out 0x107
mem[54] = {op_br,   4'd5,  4'd3, 19'd2};            // brmi r5 taken
mem[55] = {op_ldi,  4'd12, 4'd0, 19'hbad};
mem[56] = {op_out,  4'd12, 4'd0, 19'd0};
mem[57] = {op_ldi,  4'd12, 4'd0, 19'h108};
mem[58] = {op_out,  4'd12, 4'd0, 19'd0};            // out 0x108
// input port
mem[59] = {op_in,   4'd13, 4'd0, 19'd0};            // in r13
mem[60] = {op_addi, 4'd14, 4'd13, 19'd5};           // addi r14, r13, 5
mem[61] = {op_out,  4'd14, 4'd0, 19'd0};            // out in_port + 5
mem[62] = {op_nop,  27'd0};
mem[63] = {op_halt, 27'd0};

mem[100] = 32'h1357_9bdf;                           // preloaded data word

`endif

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

	// sizing
	localparam int data_width     = 32;
	localparam int mem_depth      = 512;
	localparam int addr_width     = $clog2(mem_depth);   // 9 bit word address
	localparam int reg_count      = 16;
	localparam int reg_addr_width = $clog2(reg_count);
	localparam int imm_width      = 19;
	localparam int shamt_width    = $clog2(data_width);  // shifts use low 5 bits of b

	// branch condition codes, low 2 bits of the rb field
	localparam logic [1:0] cond_zr = 2'd0;
	localparam logic [1:0] cond_nz = 2'd1;
	localparam logic [1:0] cond_pl = 2'd2;
	localparam logic [1:0] cond_mi = 2'd3;

	// write back source
	localparam logic [1:0] wb_alu = 2'd0;
	localparam logic [1:0] wb_mdr = 2'd1;
	localparam logic [1:0] wb_in  = 2'd2;

	localparam logic b_reg    = 1'b0;   // alu b from register port b
	localparam logic b_imm    = 1'b1;   // alu b from sign extended immediate
	localparam logic addr_pc  = 1'b0;
	localparam logic addr_alu = 1'b1;

	typedef enum logic [4:0] {
		op_ld   = 5'd0,
		op_ldi  = 5'd1,
		op_st   = 5'd2,
		op_add  = 5'd3,
		op_sub  = 5'd4,
		op_shr  = 5'd5,
		op_shl  = 5'd7,
		op_and  = 5'd10,
		op_or   = 5'd11,
		op_addi = 5'd12,
		op_andi = 5'd13,
		op_ori  = 5'd14,
		op_br   = 5'd19,
		op_in   = 5'd22,
		op_out  = 5'd23,
		op_nop  = 5'd26,
		op_halt = 5'd27
	} opcode_e;

	typedef enum logic [2:0] {
		alu_pass_b, alu_add, alu_sub, alu_and, alu_or, alu_shr, alu_shl
	} alu_op_e;

	typedef enum logic [3:0] {
		fetch_addr, fetch_load, decode, exec_alu, mem_addr, mem_read,
		mem_write, write_back, branch, io, halted_st
	} state_e;

	// rc sits in the top of the immediate field
	typedef struct packed {
		logic [reg_addr_width-1:0] rc;
		logic [imm_width-reg_addr_width-1:0] rsvd;
	} rc_field_t;

	typedef union packed {
		logic [imm_width-1:0] imm;
		rc_field_t            r;
	} low_field_t;

	typedef struct packed {
		opcode_e                   opcode;
		logic [reg_addr_width-1:0] ra;
		logic [reg_addr_width-1:0] rb;   // base reg, or branch cond in low 2 bits
		low_field_t                low;
	} instr_t;

	typedef struct packed {
		logic    pc_inc;
		logic    pc_load;
		logic    ir_load;
		logic    mdr_load;
		logic    reg_write;
		logic [1:0] wb_sel;
		logic    mem_read;
		logic    mem_write;
		logic    mem_addr_sel;
		alu_op_e alu_op;
		logic    b_sel;
		logic    out_load;
	} ctrl_t;

endpackage

// ==== source/ram.sv ====
`timescale 1ns/10ps

module ram
	import cpu_pkg::*;
(
	input  logic                  clock,
	input  logic [data_width-1:0] data_in,
	input  logic [addr_width-1:0] address,
	input  logic                  read,
	input  logic                  write,
	output logic [data_width-1:0] data_out
);

	logic [data_width-1:0] mem [0:mem_depth-1];

	// program image, everything else starts at zero
	initial begin
		foreach (mem[i]) begin
			mem[i] = '0;
		end
		`include "demo_program.svh"
	end

	always_ff @(posedge clock) begin
		if (write) begin
			mem[address] <= data_in;   // write lands on the edge
		end
	end

	// read is combinational, bus idles at zero
	assign data_out = read ? mem[address] : '0;

	a_no_read_write: assert property (@(posedge clock) !(read && write))
		else $error("ram read and write strobes active together");

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/10ps

module register_file
	import cpu_pkg::*;
(
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic [reg_addr_width-1:0] ra_addr,
	input  logic [reg_addr_width-1:0] rb_addr,
	input  logic [reg_addr_width-1:0] wr_addr,
	input  logic                      wr_en,
	input  logic [data_width-1:0]     wr_data,
	output logic [data_width-1:0]     ra_data,
	output logic [data_width-1:0]     rb_data
);

	logic [data_width-1:0] regs [0:reg_count-1];

	// r0 is an ordinary register here
	// zero base for ld/ldi/st comes from the alu pass_b path
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			regs <= '{default: '0};
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign ra_data = regs[ra_addr];   // alu a, or branch test value
	assign rb_data = regs[rb_addr];   // alu b, store data, out data

endmodule

// ==== source/alu.sv ====
`timescale 1ns/10ps

module alu
	import cpu_pkg::*;
(
	input  alu_op_e               op,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	input  logic [1:0]            cond,
	output logic [data_width-1:0] result,
	output logic                  cond_true
);

	logic [shamt_width-1:0] shamt;
	logic                   a_zero;
	logic                   a_neg;

	assign shamt  = b[shamt_width-1:0];
	assign a_zero = (a == '0);
	assign a_neg  = a[data_width-1];

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_shr: result = a >> shamt;   // logical, zero fill
			alu_shl: result = a << shamt;
			default: result = b;            // pass_b, base masked off
		endcase
	end

	// branch test always looks at a
	always_comb begin
		case (cond)
			cond_zr: cond_true = a_zero;
			cond_nz: cond_true = !a_zero;
			cond_pl: cond_true = !a_neg && !a_zero;   // strictly positive
			default: cond_true = a_neg;               // cond_mi
		endcase
	end

endmodule

// ==== source/program_counter.sv ====
`timescale 1ns/10ps

module program_counter
	import cpu_pkg::*;
(
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  inc,
	input  logic                  load,
	input  logic [addr_width-1:0] target,
	output logic [addr_width-1:0] pc
);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (load) begin
			pc <= target;          // taken branch
		end else if (inc) begin
			pc <= pc + 1'b1;       // after fetch, wraps at mem_depth
		end
	end

	a_inc_load_excl: assert property (@(posedge clock) disable iff (!rst_n) !(inc && load))
		else $error("pc increment and load in the same cycle");

endmodule

// ==== source/control_unit.sv ====
`timescale 1ns/10ps

module control_unit
	import cpu_pkg::*;
(
	input  logic   clock,
	input  logic   rst_n,
	input  instr_t instr,
	input  logic   cond_true,
	output ctrl_t  ctrl,
	output logic   out_strobe,
	output logic   halted
);

	state_e  state;
	state_e  state_next;
	opcode_e op;
	alu_op_e alu_sel;
	logic    rtype;
	logic    no_base;

	assign op      = instr.opcode;
	assign rtype   = op inside {op_add, op_sub, op_and, op_or, op_shr, op_shl};
	assign no_base = (instr.rb == '0);   // base field 0 means absolute address

	// alu function is fixed per instruction
	always_comb begin
		case (op)
			op_ld, op_ldi, op_st: alu_sel = no_base ? alu_pass_b : alu_add;
			op_add, op_addi:      alu_sel = alu_add;
			op_sub:               alu_sel = alu_sub;
			op_and, op_andi:      alu_sel = alu_and;
			op_or, op_ori:        alu_sel = alu_or;
			op_shr:               alu_sel = alu_shr;
			op_shl:               alu_sel = alu_shl;
			default:              alu_sel = alu_pass_b;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= fetch_addr;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = fetch_addr;   // most steps return to fetch
		case (state)
			fetch_addr: state_next = fetch_load;
			fetch_load: state_next = decode;
			decode: begin
				case (op)
					op_ld, op_st: state_next = mem_addr;
					op_ldi, op_add, op_sub, op_and, op_or, op_shr, op_shl,
					op_addi, op_andi, op_ori: state_next = exec_alu;
					op_br:                    state_next = branch;
					op_in, op_out, op_nop:    state_next = io;
					op_halt:                  state_next = halted_st;
					default:                  state_next = fetch_addr;   // unknown acts as nop
				endcase
			end
			exec_alu:  state_next = write_back;
			mem_addr:  state_next = (op == op_ld) ? mem_read : mem_write;
			mem_read:  state_next = write_back;
			halted_st: state_next = halted_st;   // only reset leaves
			default:   state_next = fetch_addr;
		endcase
	end

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = alu_sel;
		ctrl.b_sel  = rtype ? b_reg : b_imm;   // also frees port b for st/out data
		case (state)
			fetch_addr: begin
				ctrl.mem_read     = 1'b1;
				ctrl.mem_addr_sel = addr_pc;
			end
			fetch_load: begin
				ctrl.mem_read = 1'b1;   // word still on the bus
				ctrl.ir_load  = 1'b1;
				ctrl.pc_inc   = 1'b1;
			end
			mem_addr: ctrl.mem_addr_sel = addr_alu;
			mem_read: begin
				ctrl.mem_read     = 1'b1;
				ctrl.mem_addr_sel = addr_alu;
				ctrl.mdr_load     = 1'b1;
			end
			mem_write: begin
				ctrl.mem_write    = 1'b1;
				ctrl.mem_addr_sel = addr_alu;
			end
			write_back: begin
				ctrl.reg_write = 1'b1;
				ctrl.wb_sel    = (op == op_ld) ? wb_mdr : wb_alu;
			end
			branch: ctrl.pc_load = cond_true;   // pc already points past the branch
			io: begin
				if (op == op_in) begin
					ctrl.reg_write = 1'b1;
					ctrl.wb_sel    = wb_in;
				end
				ctrl.out_load = (op == op_out);
			end
			default: ;
		endcase
	end

	// pulse lines up with the new out_port value
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			out_strobe <= 1'b0;
		end else begin
			out_strobe <= ctrl.out_load;
		end
	end

	assign halted = (state == halted_st);

	a_mem_excl: assert property (@(posedge clock) disable iff (!rst_n)
		!(ctrl.mem_read && ctrl.mem_write))
		else $error("memory read and write requested together");

	a_pc_excl: assert property (@(posedge clock) disable iff (!rst_n)
		!(ctrl.pc_inc && ctrl.pc_load))
		else $error("pc increment and load requested together");

	a_halt_sticky: assert property (@(posedge clock) disable iff (!rst_n)
		state == halted_st |=> state == halted_st)
		else $error("left halted state without reset");

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top
	import cpu_pkg::*;
(
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic [data_width-1:0] in_port,
	output logic [data_width-1:0] out_port,
	output logic                  out_strobe,
	output logic                  halted
);

	ctrl_t                     ctrl;
	instr_t                    ir;
	logic [data_width-1:0]     mdr;
	logic [addr_width-1:0]     pc;
	logic [addr_width-1:0]     pc_target;
	logic [addr_width-1:0]     ram_addr;
	logic [data_width-1:0]     ram_dout;
	logic [reg_addr_width-1:0] ra_sel;
	logic [reg_addr_width-1:0] rb_sel;
	logic [data_width-1:0]     ra_data;
	logic [data_width-1:0]     rb_data;
	logic [data_width-1:0]     imm_ext;
	logic [data_width-1:0]     alu_b;
	logic [data_width-1:0]     alu_result;
	logic [data_width-1:0]     wb_data;
	logic                      cond_true;

	assign imm_ext   = {{(data_width-imm_width){ir.low.imm[imm_width-1]}}, ir.low.imm};
	assign pc_target = pc + imm_ext[addr_width-1:0];   // relative to incremented pc

	// port a tests ra on branches, otherwise reads the base/first source
	assign ra_sel = (ir.opcode == op_br) ? ir.ra : ir.rb;
	assign rb_sel = (ctrl.b_sel == b_reg) ? ir.low.r.rc : ir.ra;
	assign alu_b  = (ctrl.b_sel == b_imm) ? imm_ext : rb_data;

	assign ram_addr = (ctrl.mem_addr_sel == addr_alu) ? alu_result[addr_width-1:0] : pc;

	always_comb begin
		case (ctrl.wb_sel)
			wb_mdr:  wb_data = mdr;
			wb_in:   wb_data = in_port;
			wb_alu:  wb_data = alu_result;
			default: wb_data = alu_result;
		endcase
	end

	always_ff @(posedge clock) begin
		if (ctrl.ir_load) begin
			ir <= instr_t'(ram_dout);
		end
		if (ctrl.mdr_load) begin
			mdr <= ram_dout;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			out_port <= '0;
		end else if (ctrl.out_load) begin
			out_port <= rb_data;   // holds until the next out
		end
	end

	control_unit i_control_unit (
		.clock      (clock),
		.rst_n      (rst_n),
		.instr      (ir),
		.cond_true  (cond_true),
		.ctrl       (ctrl),
		.out_strobe (out_strobe),
		.halted     (halted)
	);

	program_counter i_program_counter (
		.clock  (clock),
		.rst_n  (rst_n),
		.inc    (ctrl.pc_inc),
		.load   (ctrl.pc_load),
		.target (pc_target),
		.pc     (pc)
	);

	register_file i_register_file (
		.clock   (clock),
		.rst_n   (rst_n),
		.ra_addr (ra_sel),
		.rb_addr (rb_sel),
		.wr_addr (ir.ra),
		.wr_en   (ctrl.reg_write),
		.wr_data (wb_data),
		.ra_data (ra_data),
		.rb_data (rb_data)
	);

	alu i_alu (
		.op        (ctrl.alu_op),
		.a         (ra_data),
		.b         (alu_b),
		.cond      (ir.rb[1:0]),
		.result    (alu_result),
		.cond_true (cond_true)
	);

	ram i_ram (
		.clock    (clock),
		.data_in  (rb_data),   // st source register
		.address  (ram_addr),
		.read     (ctrl.mem_read),
		.write    (ctrl.mem_write),
		.data_out (ram_dout)
	);

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;   // 10 ns period
	end

	// reset low for the first 3 cycles, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (3) @(negedge clock);
		rst_n = 1'b1;
	end

endmodule

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/10ps

module tb_cpu
	import cpu_pkg::*;
();

	localparam int row_count    = 20;
	localparam int strobe_limit = 200;   // cycles allowed per out event
	localparam int halt_limit   = 50;
	localparam int quiet_cycles = 50;    // no out pulses after halt
	localparam int reset_limit  = 20;

	// one expected out event
	typedef struct packed {
		logic                  from_in;   // value is in_port + 5
		logic [data_width-1:0] value;
	} out_row_t;

	logic                  clock;
	logic                  rst_n;
	logic [data_width-1:0] in_port;
	logic [data_width-1:0] out_port;
	logic                  out_strobe;
	logic                  halted;

	out_row_t              rows [row_count];
	string                 labels [row_count];
	int                    value_errors;
	int                    timeout_errors;
	logic [data_width-1:0] in_value;   // random word driven on in_port

	tb_clock i_tb_clock (
		.clock (clock),
		.rst_n (rst_n)
	);

	cpu_top i_cpu_top (
		.clock      (clock),
		.rst_n      (rst_n),
		.in_port    (in_port),
		.out_port   (out_port),
		.out_strobe (out_strobe),
		.halted     (halted)
	);

	task automatic add_row(input int idx, input logic from_in,
			input logic [data_width-1:0] value, input string label);
		rows[idx].from_in = from_in;
		rows[idx].value   = value;
		labels[idx]       = label;
	endtask

	// expected outputs worked out from the program by hand
	task automatic load_table();
		add_row(0,  1'b0, 32'h0000_0011, "add 12+5");
		add_row(1,  1'b0, 32'h0000_0007, "sub 12-5");
		add_row(2,  1'b0, 32'h0000_0004, "and 12&5");
		add_row(3,  1'b0, 32'h0000_000d, "or 12|5");
		add_row(4,  1'b0, 32'h0000_0180, "shl 12<<5");
		add_row(5,  1'b0, 32'h0000_000c, "shr 0x180>>5");
		add_row(6,  1'b0, 32'hffff_fff8, "addi 12-20");
		add_row(7,  1'b0, 32'h0000_00f8, "andi -8&0xff");
		add_row(8,  1'b0, 32'h0000_030c, "ori 12|0x300");
		add_row(9,  1'b0, 32'h0000_0404, "st then ld with negative offset");
		add_row(10, 1'b0, 32'h1357_9bdf, "ld preloaded word");
		add_row(11, 1'b0, 32'h0000_0101, "brzr not taken");
		add_row(12, 1'b0, 32'h0000_0102, "brzr taken");
		add_row(13, 1'b0, 32'h0000_0103, "brnz not taken");
		add_row(14, 1'b0, 32'h0000_0104, "brnz taken");
		add_row(15, 1'b0, 32'h0000_0105, "brpl not taken");
		add_row(16, 1'b0, 32'h0000_0106, "brpl taken");
		add_row(17, 1'b0, 32'h0000_0107, "brmi not taken");
		add_row(18, 1'b0, 32'h0000_0108, "brmi taken");
		add_row(19, 1'b1, 32'h0000_0000, "in plus 5");
	endtask

	task automatic compare_word(input logic [data_width-1:0] got,
			input logic [data_width-1:0] expected, input string label);
		if (got !== expected) begin
			value_errors++;
			$display("[FAIL] %0t %s: got %h, expected %h", $time, label, got, expected);
		end
	endtask

	task automatic compare_flag(input logic got, input logic expected, input string label);
		if (got !== expected) begin
			value_errors++;
			$display("[FAIL] %0t %s: got %b, expected %b", $time, label, got, expected);
		end
	endtask

	// rst_n moves on a falling edge and is steady by the next rising one
	task automatic wait_for_reset_release(output logic seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < reset_limit) begin
			@(posedge clock);
			seen = rst_n;
			n++;
		end
	endtask

	task automatic wait_for_strobe(output logic seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < strobe_limit) begin
			@(negedge clock);   // outputs settled mid cycle
			seen = out_strobe;
			n++;
		end
	endtask

	task automatic wait_for_halt(output logic seen);
		int n;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < halt_limit) begin
			@(negedge clock);
			seen = halted;
			n++;
		end
	endtask

	initial begin
		logic                  seen;
		logic                  stop;
		logic [data_width-1:0] expected;
		in_port        = '0;
		value_errors   = 0;
		timeout_errors = 0;
		stop           = 1'b0;
		void'($urandom(2281));   // single seed for the run
		load_table();

		@(negedge clock);   // still in reset
		compare_flag(out_strobe, 1'b0, "out_strobe in reset");
		compare_flag(halted, 1'b0, "halted in reset");
		compare_word(out_port, '0, "out_port in reset");
		in_value = $urandom;
		in_port  = in_value;   // held until the in instruction samples it

		wait_for_reset_release(seen);
		if (!seen) begin
			$display("timeout: rst_n never went high");
			timeout_errors++;
			stop = 1'b1;
		end else begin
			@(negedge clock);
			compare_flag(out_strobe, 1'b0, "out_strobe after reset");
			compare_flag(halted, 1'b0, "halted after reset");
			compare_word(out_port, '0, "out_port after reset");
		end

		for (int i = 0; i < row_count && !stop; i++) begin
			wait_for_strobe(seen);
			if (!seen) begin
				$display("timeout: no out_strobe within %0d cycles for row %0d (%s)",
					strobe_limit, i, labels[i]);
				timeout_errors++;
				stop = 1'b1;   // program is lost so the rest is skipped
			end else begin
				expected = rows[i].from_in ? in_value + 32'd5 : rows[i].value;
				compare_word(out_port, expected, labels[i]);
			end
		end

		if (!stop) begin
			wait_for_halt(seen);
			if (!seen) begin
				$display("timeout: halted did not rise within %0d cycles", halt_limit);
				timeout_errors++;
			end else begin
				repeat (quiet_cycles) begin
					@(negedge clock);
					compare_flag(out_strobe, 1'b0, "out_strobe after halt");
					compare_flag(halted, 1'b1, "halted stays high");
				end
			end
		end

		$display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+include
source/cpu_pkg.sv
source/ram.sv
source/register_file.sv
source/alu.sv
source/program_counter.sv
source/control_unit.sv
source/cpu_top.sv
testbench/tb_clock.sv
testbench/tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_cpu -o sim_cpu \
	&& ./obj_dir/sim_cpu | tee /dev/stderr | grep -q "^TESTS PASSED$" \
	&& exit 0 \
	|| exit 1
